/* dv/lane_cases.txt */
// Columns opcode imm_form thread_id word wb_index wb_data flags
// Flags hold zero in bit 1 and negative in bit 0
// Reset state and immediate loads
1 0 0 00000823 03 00000000 2
1 1 0 00001401 01 00000005 0
1 1 0 03FFF402 02 FFFFFFFD 1
1 1 0 01FFFC04 04 00007FFF 0
1 1 0 02000007 07 FFFF8000 1
0 0 0 00000005 00 00000000 0
// Register-register opcodes
1 0 0 000004A6 06 00000005 0
2 0 0 00000828 08 00000008 0
2 0 0 000004C9 09 00000000 2
3 0 0 0000104A 0A 00007FFD 0
4 0 0 000004EB 0B FFFF8005 1
5 0 0 00001D6C 0C 00000005 0
6 0 0 0000202D 0D 00000500 0
7 0 0 0000044E 0E 07FFFFFF 0
8 0 0 0000044F 0F 00000001 0
8 0 0 00000830 10 00000000 2
9 0 0 00002091 11 0003FFF8 0
9 0 0 000008F2 12 00018000 0
// Dependent chain on r19 and r20
1 1 0 00000673 13 00000001 0
1 1 0 00000673 13 00000002 0
1 0 0 00004E74 14 00000004 0
2 0 0 00004E93 13 00000002 0
1 1 0 03FFFA75 15 00000000 2
// Thread slicing with wrap past r31
1 1 3 04015414 17 00000055 0
1 1 5 07FFFC1E 03 FFFFFFFF 1
1 0 F 0003D116 05 00000054 0
1 0 9 00005CB8 18 000000A9 0
1 1 3 080043D9 19 00000015 0
2 0 0 0000303A 1A 00000000 2
0 0 6 00000000 00 00000000 0

/* dv/lane_unit_checker.sv */
`timescale 1ns/1ns
`default_nettype none

module lane_unit_checker (
	input logic               clock,
	input logic               rst_n,
	input logic               cmd_valid,
	input lane_pkg::command_t cmd,
	input lane_pkg::wb_t      wb,
	input lane_pkg::stat_t    status
);

	int   fail_count = 0;
	logic issued;

	assign issued = cmd_valid && (cmd.opcode != lane_pkg::OP_NOP);

	////////////////////////////////////////
	// Commit strobe timing
	wb_after_issue: assert property (@(posedge clock) disable iff (!rst_n)
		issued |-> ##3 wb.valid)
	else begin
		$error("wb.valid missing three cycles after a command");
		fail_count++;
	end

	wb_only_after_issue: assert property (@(posedge clock) disable iff (!rst_n)
		wb.valid |-> $past(issued, 3))
	else begin
		$error("wb.valid without a matching command");
		fail_count++;
	end

	////////////////////////////////////////
	// Reset state and status hold
	reset_state: assert property (@(posedge clock)
		!rst_n |-> (!wb.valid && (status == '0)))
	else begin
		$error("wb.valid or status not clear during reset");
		fail_count++;
	end

	status_hold: assert property (@(posedge clock) disable iff (!rst_n)
		!$stable(status) |-> wb.valid)
	else begin
		$error("status changed without a writeback");
		fail_count++;
	end

endmodule

bind lane_unit lane_unit_checker checker0 (
	.clock(		clock		),
	.rst_n(		rst_n		),
	.cmd_valid(	cmd_valid	),
	.cmd(		cmd			),
	.wb(		wb			),
	.status(	status		)
);

`default_nettype wire

/* dv/lane_unit_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module lane_unit_tb;

	localparam int          CLK_PERIOD   = 20;
	localparam int          DRIVE_DELAY  = 2;
	localparam int          RESET_CYCLES = 5;
	localparam int          MAX_CASES    = 64;
	localparam int          CASE_COLS    = 7;
	localparam logic [15:0] LFSR_SEED    = 16'd4196;

	logic               clock;
	logic               rst_n;
	logic               cmd_valid;
	lane_pkg::command_t cmd;
	lane_pkg::wb_t      wb;
	lane_pkg::stat_t    status;

	logic [31:0]        case_mem [MAX_CASES*CASE_COLS];
	int                 num_cases;
	logic               loaded;
	logic [15:0]        lfsr;
	lane_pkg::wb_t      wb_q [$];
	lane_pkg::stat_t    stat_q [$];
	lane_pkg::stat_t    last_status;

	lane_unit dut0 (
		.clock(		clock		),
		.rst_n(		rst_n		),
		.cmd_valid(	cmd_valid	),
		.cmd(		cmd			),
		.wb(		wb			),
		.status(	status		)
	);

	always #(CLK_PERIOD/2) clock = ~clock;

	////////////////////////////////////////
	// Helpers
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};		// x^16+x^14+x^13+x^11+1
	endfunction

	task automatic draw_bits(input int n, output int value);
		value = 0;
		for (int i = 0; i < n; i++) begin
			value = (value << 1) | lfsr[15];
			lfsr  = lfsr_next(lfsr);
		end
	endtask

	task automatic abort_run(input string line);
		$display("%s", line);
		$display("Some tests failed");
		$fatal(1);
	endtask

	task automatic check_wb(input lane_pkg::wb_t got, input lane_pkg::wb_t exp);
		if (got !== exp) begin
			abort_run($sformatf("[FAIL] %0t ns wb: got %0b/%0d/%h, expected %0b/%0d/%h",
				$time, got.valid, got.index, got.data, exp.valid, exp.index, exp.data));
		end
	endtask

	task automatic check_status(input lane_pkg::stat_t got, input lane_pkg::stat_t exp);
		if (got !== exp) begin
			abort_run($sformatf("[FAIL] %0t ns status: got z=%0b n=%0b, expected z=%0b n=%0b",
				$time, got.zero, got.negative, exp.zero, exp.negative));
		end
	endtask

	task automatic drive_command(input lane_pkg::command_t c);
		@(posedge clock);
		#DRIVE_DELAY;
		cmd_valid = 1'b1;
		cmd       = c;
	endtask

	task automatic drive_idle();
		@(posedge clock);
		#DRIVE_DELAY;
		cmd_valid = 1'b0;
		cmd       = '0;
	endtask

	////////////////////////////////////////
	// Monitor
	always @(negedge clock) begin
		if (rst_n) begin
			if (dut0.checker0.fail_count != 0) begin
				abort_run("An assertion in the bound checker failed");
			end
			if (wb.valid) begin
				if (wb_q.size() == 0) begin
					abort_run("Writeback seen with no command outstanding");
				end else begin
					check_wb(wb, wb_q.pop_front());
					last_status = stat_q.pop_front();
				end
			end
			check_status(status, last_status);		// Holds between writebacks
		end
	end

	initial begin
		int limit_ns;

		wait (loaded);
		limit_ns = num_cases * 7 * CLK_PERIOD + 1000;
		#(limit_ns);
		abort_run($sformatf("Timeout: run did not finish within %0d ns", limit_ns));
	end

	////////////////////////////////////////
	// Stimulus
	initial begin
		lane_pkg::command_t c;
		lane_pkg::wb_t      exp_wb;
		int                 gap;
		int                 base;

		clock       = 1'b0;
		rst_n       = 1'b0;
		cmd_valid   = 1'b0;
		cmd         = '0;
		loaded      = 1'b0;
		lfsr        = LFSR_SEED;
		last_status = '0;
		num_cases   = 0;

		for (int i = 0; i < MAX_CASES * CASE_COLS; i++) begin
			case_mem[i] = '1;		// Unused rows
		end
		$readmemh("dv/lane_cases.txt", case_mem);
		while (num_cases < MAX_CASES && case_mem[num_cases * CASE_COLS] != '1) begin
			num_cases++;
		end
		if (num_cases == 0) begin
			abort_run("No cases could be read from dv/lane_cases.txt");
		end
		loaded = 1'b1;

		repeat (RESET_CYCLES) @(posedge clock);
		#DRIVE_DELAY;
		rst_n = 1'b1;

		for (int n = 0; n < num_cases; n++) begin
			base        = n * CASE_COLS;
			c.opcode    = lane_pkg::opcode_t'(case_mem[base][3:0]);
			c.imm_form  = case_mem[base + 1][0];
			c.thread_id = case_mem[base + 2][lane_pkg::THREAD_WIDTH-1:0];
			c.word      = case_mem[base + 3];
			if (c.opcode != lane_pkg::OP_NOP) begin
				exp_wb.valid = 1'b1;
				exp_wb.index = case_mem[base + 4][lane_pkg::INDEX_WIDTH-1:0];
				exp_wb.data  = case_mem[base + 5];
				wb_q.push_back(exp_wb);
				stat_q.push_back(case_mem[base + 6][1:0]);
			end
			drive_command(c);
			draw_bits(2, gap);
			repeat (gap) drive_idle();
		end
		drive_idle();

		while (wb_q.size() != 0) begin
			@(posedge clock);
		end
		repeat (4) @(posedge clock);		// No stray writebacks
		@(negedge clock);

		if (dut0.checker0.fail_count != 0) begin
			abort_run("An assertion in the bound checker failed");
		end else begin
			$display("All tests passed");
			$finish;
		end
	end

endmodule

`default_nettype wire

/* files.f */
verilog/lane_pkg.sv
verilog/lane_index_unit.sv
verilog/lane_reg_bank.sv
verilog/lane_math_unit.sv
verilog/lane_unit.sv
dv/lane_unit_checker.sv
dv/lane_unit_tb.sv

/* verilog/lane_index_unit.sv */
`timescale 1ns/1ns
`default_nettype none

module lane_index_unit (
	input  logic               clock,
	input  logic               rst_n,
	input  logic               cmd_valid,
	input  lane_pkg::command_t cmd,
	output lane_pkg::issue_t   issue,
	output lane_pkg::rd_req_t  rd_req
);

	lane_pkg::instr_rr_t  rr;
	lane_pkg::instr_imm_t im;
	lane_pkg::index_t     dst_idx;
	lane_pkg::index_t     src1_idx;
	lane_pkg::index_t     src2_idx;
	lane_pkg::data_t      imm_ext;
	lane_pkg::rd_req_t    rd_req_d;

	function automatic lane_pkg::index_t slice_index(
		input lane_pkg::index_t  field,
		input logic              slice,
		input lane_pkg::thread_t tid
	);
		return slice ? field + lane_pkg::index_t'(tid) : field;		// Wraps past r31
	endfunction

	////////////////////////////////////////
	// Decode
	assign rr = cmd.word.rr;
	assign im = cmd.word.imm;

	assign imm_ext = {{(lane_pkg::DATA_WIDTH-lane_pkg::IMM_WIDTH){im.imm[lane_pkg::IMM_WIDTH-1]}},
		im.imm};

	always_comb begin
		if (cmd.imm_form) begin
			dst_idx  = slice_index(im.dst, im.slice_dst, cmd.thread_id);
			src1_idx = slice_index(im.src1, im.slice_src1, cmd.thread_id);
			src2_idx = '0;		// Immediate takes operand 2
		end else begin
			dst_idx  = slice_index(rr.dst, rr.slice_dst, cmd.thread_id);
			src1_idx = slice_index(rr.src1, rr.slice_src1, cmd.thread_id);
			src2_idx = slice_index(rr.src2, rr.slice_src2, cmd.thread_id);
		end
	end

	////////////////////////////////////////
	// Bank split
	always_comb begin
		rd_req_d.src1          = src1_idx;
		rd_req_d.src2          = src2_idx;
		rd_req_d.src1_odd      = src1_idx[0];
		rd_req_d.src2_odd      = src2_idx[0];
		rd_req_d.odd_index[0]  = src1_idx[0] ? src1_idx[lane_pkg::INDEX_WIDTH-1:1] : '0;
		rd_req_d.even_index[0] = src1_idx[0] ? '0 : src1_idx[lane_pkg::INDEX_WIDTH-1:1];
		rd_req_d.odd_index[1]  = src2_idx[0] ? src2_idx[lane_pkg::INDEX_WIDTH-1:1] : '0;
		rd_req_d.even_index[1] = src2_idx[0] ? '0 : src2_idx[lane_pkg::INDEX_WIDTH-1:1];
	end

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			issue <= '0;
		end else begin
			issue.valid <= cmd_valid;
			if (cmd_valid) begin
				issue.opcode   <= cmd.opcode;
				issue.imm_form <= cmd.imm_form;
				issue.imm      <= imm_ext;
				issue.dst      <= dst_idx;
				issue.write_en <= (cmd.opcode != lane_pkg::OP_NOP);
			end
		end
	end

	always_ff @(posedge clock) begin
		if (cmd_valid) begin
			rd_req <= rd_req_d;		// Held between commands
		end
	end

endmodule

`default_nettype wire

/* verilog/lane_math_unit.sv */
`timescale 1ns/1ns
`default_nettype none

module lane_math_unit (
	input  logic              clock,
	input  logic              rst_n,
	input  lane_pkg::issue_t  issue,
	input  lane_pkg::rd_req_t rd_req,
	input  lane_pkg::data_t   odd_data1,
	input  lane_pkg::data_t   odd_data2,
	input  lane_pkg::data_t   even_data1,
	input  lane_pkg::data_t   even_data2,
	output lane_pkg::wb_t     wb,
	output lane_pkg::stat_t   status
);

	lane_pkg::issue_t issue_q;
	logic             src1_odd_q;
	logic             src2_odd_q;
	lane_pkg::index_t src1_q;
	lane_pkg::index_t src2_q;

	lane_pkg::data_t  bank_op1;
	lane_pkg::data_t  bank_op2;
	lane_pkg::data_t  op1;
	lane_pkg::data_t  op2;
	lane_pkg::data_t  result;
	logic             fwd1;
	logic             fwd2;
	logic             wb_en;

	logic             wb_valid_q;
	lane_pkg::index_t wb_index_q;
	lane_pkg::data_t  wb_data_q;

	////////////////////////////////////////
	// Align with bank data
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			issue_q <= '0;
		end else begin
			issue_q <= issue;
		end
	end

	always_ff @(posedge clock) begin
		src1_odd_q <= rd_req.src1_odd;
		src2_odd_q <= rd_req.src2_odd;
		src1_q     <= rd_req.src1;
		src2_q     <= rd_req.src2;
	end

	////////////////////////////////////////
	// Operand select and forwarding
	assign bank_op1 = src1_odd_q ? odd_data1 : even_data1;
	assign bank_op2 = src2_odd_q ? odd_data2 : even_data2;

	// Result still in the wb register has not reached the bank read
	assign fwd1 = wb_valid_q && (wb_index_q == src1_q);
	assign fwd2 = wb_valid_q && (wb_index_q == src2_q);

	assign op1 = fwd1 ? wb_data_q : bank_op1;

	always_comb begin
		if (issue_q.imm_form) begin
			op2 = issue_q.imm;
		end else if (fwd2) begin
			op2 = wb_data_q;
		end else begin
			op2 = bank_op2;
		end
	end

	////////////////////////////////////////
	// ALU
	always_comb begin
		case (issue_q.opcode)
			lane_pkg::OP_ADD: result = op1 + op2;
			lane_pkg::OP_SUB: result = op1 - op2;
			lane_pkg::OP_AND: result = op1 & op2;
			lane_pkg::OP_OR:  result = op1 | op2;
			lane_pkg::OP_XOR: result = op1 ^ op2;
			lane_pkg::OP_SLL: result = op1 << op2[lane_pkg::SHAMT_WIDTH-1:0];
			lane_pkg::OP_SRL: result = op1 >> op2[lane_pkg::SHAMT_WIDTH-1:0];
			lane_pkg::OP_SLT: result = lane_pkg::data_t'($signed(op1) < $signed(op2));
			lane_pkg::OP_MUL: result = op1 * op2;		// Truncated to data width
			default:          result = '0;
		endcase
	end

	assign wb_en = issue_q.valid && issue_q.write_en;

	////////////////////////////////////////
	// Writeback and status
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			wb_valid_q <= 1'b0;
		end else begin
			wb_valid_q <= wb_en;
		end
	end

	always_ff @(posedge clock) begin
		if (wb_en) begin
			wb_index_q <= issue_q.dst;
			wb_data_q  <= result;
		end
	end

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			status <= '0;
		end else if (wb_en) begin
			status.zero     <= (result == '0);
			status.negative <= result[lane_pkg::DATA_WIDTH-1];
		end
	end

	assign wb = '{valid: wb_valid_q, index: wb_index_q, data: wb_data_q};

endmodule

`default_nettype wire

/* verilog/lane_pkg.sv */
`default_nettype none

package lane_pkg;

	////////////////////////////////////////
	// Widths
	localparam int DATA_WIDTH       = 32;
	localparam int INDEX_WIDTH      = 5;
	localparam int BANK_INDEX_WIDTH = 4;
	localparam int THREAD_WIDTH     = 4;
	localparam int IMM_WIDTH        = 16;
	localparam int SHAMT_WIDTH      = 5;

	typedef logic [DATA_WIDTH-1:0]       data_t;
	typedef logic [INDEX_WIDTH-1:0]      index_t;		// Bit 0 set selects odd bank
	typedef logic [BANK_INDEX_WIDTH-1:0] bank_index_t;
	typedef logic [THREAD_WIDTH-1:0]     thread_t;

	////////////////////////////////////////
	// Instruction encoding
	typedef enum logic [3:0] {
		OP_NOP,
		OP_ADD,
		OP_SUB,
		OP_AND,
		OP_OR,
		OP_XOR,
		OP_SLL,
		OP_SRL,
		OP_SLT,		// Signed compare
		OP_MUL		// Low word of product
	} opcode_t;

	typedef struct packed {
		logic [13:0] spare;
		logic        slice_src2;
		logic        slice_src1;
		logic        slice_dst;
		index_t      src2;
		index_t      src1;
		index_t      dst;
	} instr_rr_t;

	typedef struct packed {
		logic [3:0]           spare;
		logic                 slice_src1;
		logic                 slice_dst;
		logic [IMM_WIDTH-1:0] imm;		// Sign-extended on issue
		index_t               src1;
		index_t               dst;
	} instr_imm_t;

	typedef union packed {
		instr_rr_t  rr;
		instr_imm_t imm;
	} instr_u;

	typedef struct packed {
		opcode_t opcode;
		logic    imm_form;
		thread_t thread_id;
		instr_u  word;
	} command_t;

	////////////////////////////////////////
	// Pipeline payloads
	typedef struct packed {
		bank_index_t [1:0] odd_index;		// [0] port 1, [1] port 2
		bank_index_t [1:0] even_index;
		logic              src1_odd;
		logic              src2_odd;
		index_t            src1;
		index_t            src2;
	} rd_req_t;

	typedef struct packed {
		logic    valid;
		opcode_t opcode;
		logic    imm_form;
		data_t   imm;
		index_t  dst;
		logic    write_en;
	} issue_t;

	typedef struct packed {
		logic   valid;
		index_t index;
		data_t  data;
	} wb_t;

	typedef struct packed {
		logic zero;
		logic negative;
	} stat_t;

endpackage

`default_nettype wire

/* verilog/lane_reg_bank.sv */
`timescale 1ns/1ns
`default_nettype none

module lane_reg_bank (
	input  logic              clock,
	input  logic              rst_n,
	input  logic              odd_bank,
	input  lane_pkg::rd_req_t rd_req,
	input  lane_pkg::wb_t     wb,
	output lane_pkg::data_t   rd_data1,
	output lane_pkg::data_t   rd_data2
);

	localparam int DEPTH = 2 ** lane_pkg::BANK_INDEX_WIDTH;

	lane_pkg::data_t             mem [DEPTH];
	lane_pkg::bank_index_t [1:0] rd_index;
	lane_pkg::bank_index_t       wr_index;
	logic                        rd_en1;
	logic                        rd_en2;
	logic                        we;

	assign rd_index = odd_bank ? rd_req.odd_index : rd_req.even_index;
	assign rd_en1   = (rd_req.src1_odd == odd_bank);
	assign rd_en2   = (rd_req.src2_odd == odd_bank);

	assign we       = wb.valid && (wb.index[0] == odd_bank);		// Parity match
	assign wr_index = wb.index[lane_pkg::INDEX_WIDTH-1:1];

	////////////////////////////////////////
	// Storage
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < DEPTH; i++) begin
				mem[i] <= '0;
			end
		end else if (we) begin
			mem[wr_index] <= wb.data;
		end
	end

	////////////////////////////////////////
	// Read ports with write-through
	always_ff @(posedge clock) begin
		if (rd_en1) begin
			if (we && (wr_index == rd_index[0])) begin
				rd_data1 <= wb.data;
			end else begin
				rd_data1 <= mem[rd_index[0]];
			end
		end
		if (rd_en2) begin
			if (we && (wr_index == rd_index[1])) begin
				rd_data2 <= wb.data;
			end else begin
				rd_data2 <= mem[rd_index[1]];
			end
		end
	end

endmodule

`default_nettype wire

/* verilog/lane_unit.sv */
`timescale 1ns/1ns
`default_nettype none

module lane_unit (
	input  logic               clock,
	input  logic               rst_n,
	input  logic               cmd_valid,
	input  lane_pkg::command_t cmd,
	output lane_pkg::wb_t      wb,		// Valid doubles as commit
	output lane_pkg::stat_t    status
);

	lane_pkg::issue_t  issue;
	lane_pkg::rd_req_t rd_req;
	lane_pkg::data_t   odd_data1;
	lane_pkg::data_t   odd_data2;
	lane_pkg::data_t   even_data1;
	lane_pkg::data_t   even_data2;

	////////////////////////////////////////
	// Index stage
	lane_index_unit index0 (
		.clock(		clock		),
		.rst_n(		rst_n		),
		.cmd_valid(	cmd_valid	),
		.cmd(		cmd			),
		.issue(		issue		),
		.rd_req(	rd_req		)
	);

	////////////////////////////////////////
	// Register read stage
	lane_reg_bank bank_odd (
		.clock(		clock		),
		.rst_n(		rst_n		),
		.odd_bank(	1'b1		),
		.rd_req(	rd_req		),
		.wb(		wb			),
		.rd_data1(	odd_data1	),
		.rd_data2(	odd_data2	)
	);

	lane_reg_bank bank_even (
		.clock(		clock		),
		.rst_n(		rst_n		),
		.odd_bank(	1'b0		),
		.rd_req(	rd_req		),
		.wb(		wb			),
		.rd_data1(	even_data1	),
		.rd_data2(	even_data2	)
	);

	////////////////////////////////////////
	// Execute and writeback
	lane_math_unit math0 (
		.clock(		clock		),
		.rst_n(		rst_n		),
		.issue(		issue		),
		.rd_req(	rd_req		),
		.odd_data1(	odd_data1	),
		.odd_data2(	odd_data2	),
		.even_data1(even_data1	),
		.even_data2(even_data2	),
		.wb(		wb			),
		.status(	status		)
	);

endmodule

`default_nettype wire
